//--- test/csr_trace.txt
// stall hw_int valid op num wdata mask pc ecode esub badv chk rdata flush redirect_pc plv
// op 1 rd, 2 wr, 3 xchg, 4 ertn, 5 excp; expected columns are seen one cycle later
0 00 1 2 0030 12345678 00000000 00001000 00 000 00000000 1 00000000 1 00001004 0
0 00 1 1 0030 00000000 00000000 00001004 00 000 00000000 1 12345678 0 00001004 0
0 00 1 3 0030 ffff0000 00ffff00 00001008 00 000 00000000 1 12345678 1 0000100c 0
0 00 1 1 0030 00000000 00000000 0000100c 00 000 00000000 1 12ff0078 0 0000100c 0
0 00 1 2 0005 ffffffff 00000000 00001010 00 000 00000000 1 00000000 1 00001014 0
0 00 1 1 0005 00000000 00000000 00001014 00 000 00000000 1 00000003 0 00001014 0
0 00 1 2 000c 1c000abc 00000000 00001018 00 000 00000000 1 00000000 1 0000101c 0
0 00 1 1 000c 00000000 00000000 0000101c 00 000 00000000 1 1c000a80 0 0000101c 0
0 00 1 1 0100 00000000 00000000 00001020 00 000 00000000 1 00000000 0 0000101c 0
0 00 1 2 0000 0000000b 00000000 00001024 00 000 00000000 1 00000008 1 00001028 3
0 00 1 5 0000 00000000 00000000 00002000 0b 000 00000000 1 00000008 1 1c000a80 0
0 00 1 1 0006 00000000 00000000 1c000a80 00 000 00000000 1 00002000 0 1c000a80 0
0 00 1 1 0005 00000000 00000000 1c000a84 00 000 00000000 1 000b0003 0 1c000a80 0
0 00 1 1 0001 00000000 00000000 1c000a88 00 000 00000000 1 00000003 0 1c000a80 0
0 00 1 4 0000 00000000 00000000 1c000a8c 00 000 00000000 1 00000003 1 00002000 3
0 00 1 5 0000 00000000 00000000 00003000 08 000 00000000 1 00000003 1 1c000a80 0
0 00 1 1 0007 00000000 00000000 1c000a80 00 000 00000000 1 00003000 0 1c000a80 0
1 00 1 2 0031 deadbeef 00000000 00004000 00 000 00000000 1 00003000 0 1c000a80 0
0 00 1 1 0031 00000000 00000000 00004004 00 000 00000000 1 00000000 0 1c000a80 0
0 00 1 2 0004 00000800 00000000 00005000 00 000 00000000 1 00000000 1 00005004 0
0 00 1 2 0041 00000009 00000000 00005004 00 000 00000000 1 00000000 1 00005008 0
0 00 1 2 0001 00000004 00000000 00005008 00 000 00000000 1 00000003 1 0000500c 0
0 00 1 4 0000 00000000 00000000 0000500c 00 000 00000000 1 00000003 1 00003000 0
0 00 1 1 0042 00000000 00000000 00006000 00 000 00000000 1 00000006 0 00003000 0
0 00 1 1 0042 00000000 00000000 00006004 00 000 00000000 1 00000005 0 00003000 0
0 00 1 1 0042 00000000 00000000 00006008 00 000 00000000 1 00000004 0 00003000 0
0 00 1 1 0042 00000000 00000000 0000600c 00 000 00000000 1 00000003 0 00003000 0
0 00 1 1 0042 00000000 00000000 00006010 00 000 00000000 1 00000002 0 00003000 0
0 00 1 1 0042 00000000 00000000 00006014 00 000 00000000 1 00000001 0 00003000 0
0 00 1 1 0030 00000000 00000000 00006018 00 000 00000000 1 00000001 1 1c000a80 0
0 00 1 1 0005 00000000 00000000 1c000a80 00 000 00000000 1 00000803 0 1c000a80 0
0 00 1 2 0044 00000001 00000000 1c000a84 00 000 00000000 1 00000000 1 1c000a88 0
0 00 1 1 0005 00000000 00000000 1c000a88 00 000 00000000 1 00000003 0 1c000a88 0

//--- verilog.f
common/csr_defs_pkg.sv
common/csr_port_pkg.sv
csr/csr_regfile.sv
csr/csr_timer.sv
csr/csr_trap_unit.sv
design/csr_unit.sv
test/tb_clock.sv
test/csr_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module csr_unit_tb -f verilog.f -o csr_unit_sim

output=$(./obj_dir/csr_unit_sim)
echo "$output"

if grep -qx "Test completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- test/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_defs_pkg::*;
    import csr_port_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int TRACE_LEN    = 33;
    localparam int FIELDS       = 16;   // words per trace line
    localparam int MAX_CYCLES   = RESET_CYCLES + TRACE_LEN + 20;

    logic        clk;
    logic        rstn;
    csr_req_t    req;
    logic        stall;
    logic [7:0]  hw_int;
    csr_resp_t   resp;
    crmd_t       crmd;

    logic [31:0] trace_mem [TRACE_LEN*FIELDS];
    logic [9:0]  base;
    int          row;
    int          errors;
    int          checks;
    int          cycles = 0;

    tb_clock #(
        .RESET_CYCLES (RESET_CYCLES)
    ) tb_clock_i (
        .clk  (clk),
        .rstn (rstn)
    );

    csr_unit csr_unit_i (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .stall  (stall),
        .hw_int (hw_int),
        .resp   (resp),
        .crmd   (crmd)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // one trace line, request side
    task automatic drive_line(input logic [9:0] b);
        stall        <= trace_mem[b][0];
        hw_int       <= trace_mem[b + 10'd1][7:0];
        req.valid    <= trace_mem[b + 10'd2][0];
        req.op       <= csr_op_e'(trace_mem[b + 10'd3][2:0]);
        req.num      <= trace_mem[b + 10'd4][13:0];
        req.wdata    <= trace_mem[b + 10'd5];
        req.mask     <= trace_mem[b + 10'd6];
        req.pc       <= trace_mem[b + 10'd7];
        req.ecode    <= trace_mem[b + 10'd8][5:0];
        req.esubcode <= trace_mem[b + 10'd9][8:0];
        req.badv     <= trace_mem[b + 10'd10];
    endtask

    // expected side of the same line, one cycle after it was driven
    task automatic check_line(input int line_no, input logic [9:0] b);
        if (trace_mem[b + 10'd11][0])
        begin
            check_value($sformatf("line %0d rdata", line_no),
                        trace_mem[b + 10'd12], resp.rdata);
            check_value($sformatf("line %0d flush", line_no),
                        {31'b0, trace_mem[b + 10'd13][0]}, {31'b0, resp.flush});
            check_value($sformatf("line %0d redirect_pc", line_no),
                        trace_mem[b + 10'd14], resp.redirect_pc);
            check_value($sformatf("line %0d plv", line_no),
                        {30'b0, trace_mem[b + 10'd15][1:0]}, {30'b0, crmd.plv});
        end
    endtask

    initial
    begin
        req    <= '0;
        stall  <= 1'b0;
        hw_int <= '0;
        errors = 0;
        checks = 0;
        $readmemh("test/csr_trace.txt", trace_mem);
        wait (rstn === 1'b1);
        base = '0;
        for (row = 0; row < TRACE_LEN; row++)
        begin
            @(posedge clk);
            drive_line(base);
            @(negedge clk);
            if (row > 0)
                check_line(row - 1, base - 10'd16);
            base = base + 10'd16;
        end
        @(posedge clk);
        req   <= '0;   // idle while the last line drains
        stall <= 1'b0;
        @(negedge clk);
        check_line(TRACE_LEN - 1, base - 10'd16);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: trace not finished after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rstn
);
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial
    begin
        rstn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                    clk,
    input  logic                    rstn,
    input  csr_port_pkg::csr_req_t  req,
    input  logic                    stall,
    input  logic [7:0]              hw_int,
    output csr_port_pkg::csr_resp_t resp,
    output csr_defs_pkg::crmd_t     crmd
);
    import csr_defs_pkg::*;
    import csr_port_pkg::*;

    csr_wr_t     wr;
    csr_trap_t   trap;
    csr_vec_t    vec;
    irq_ctl_t    irq;
    logic        ti;
    logic [31:0] rf_rdata;
    logic        rf_hit;
    logic [31:0] tm_rdata;
    logic        tm_hit;

    csr_regfile csr_regfile_i (
        .clk    (clk),
        .rstn   (rstn),
        .wr     (wr),
        .trap   (trap),
        .num    (req.num),
        .hw_int (hw_int),
        .ti     (ti),
        .rdata  (rf_rdata),
        .hit    (rf_hit),
        .crmd   (crmd),
        .irq    (irq),
        .vec    (vec)
    );

    csr_timer csr_timer_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (wr),
        .num   (req.num),
        .ti    (ti),
        .rdata (tm_rdata),
        .hit   (tm_hit)
    );

    csr_trap_unit csr_trap_unit_i (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .stall    (stall),
        .hw_int   (hw_int),
        .irq      (irq),
        .vec      (vec),
        .ti       (ti),
        .rf_rdata (rf_rdata),
        .rf_hit   (rf_hit),
        .tm_rdata (tm_rdata),
        .tm_hit   (tm_hit),
        .wr       (wr),
        .trap     (trap),
        .resp     (resp)
    );

endmodule

//--- csr/csr_trap_unit.sv
`timescale 1ns/1ps

module csr_trap_unit (
    input  logic                    clk,
    input  logic                    rstn,
    input  csr_port_pkg::csr_req_t  req,
    input  logic                    stall,
    input  logic [7:0]              hw_int,
    input  csr_defs_pkg::irq_ctl_t  irq,
    input  csr_defs_pkg::csr_vec_t  vec,
    input  logic                    ti,
    input  logic [31:0]             rf_rdata,
    input  logic                    rf_hit,
    input  logic [31:0]             tm_rdata,
    input  logic                    tm_hit,
    output csr_port_pkg::csr_wr_t   wr,
    output csr_port_pkg::csr_trap_t trap,
    output csr_port_pkg::csr_resp_t resp
);
    import csr_defs_pkg::*;
    import csr_port_pkg::*;

    logic [IRQ_W-1:0] irq_vec;
    logic             int_pending;
    logic             accept;
    logic             csr_access;
    logic             csr_write;
    logic [31:0]      rd_data;

    assign irq_vec     = {1'b0, ti, 1'b0, hw_int, irq.sw_is};   // bit 12 unused
    assign int_pending = |(irq_vec & irq.lie) && irq.ie;

    // an interrupt wins over the request, even under stall
    assign accept     = req.valid && !stall && !int_pending;
    assign csr_write  = accept && (req.op == OP_CSRWR || req.op == OP_CSRXCHG);
    assign csr_access = csr_write || (accept && req.op == OP_CSRRD);

    always_comb
    begin
        if (rf_hit)
            rd_data = rf_rdata;
        else if (tm_hit)
            rd_data = tm_rdata;
        else
            rd_data = '0;   // unmapped
    end

    always_comb
    begin
        wr.en  = csr_write;
        wr.num = req.num;
        if (req.op == OP_CSRXCHG)
            wr.data = (rd_data & ~req.mask) | (req.wdata & req.mask);
        else
            wr.data = req.wdata;
    end

    always_comb
    begin
        trap.kind     = TRAP_NONE;
        trap.era      = req.pc;
        trap.ecode    = req.ecode;
        trap.esubcode = req.esubcode;
        trap.badv     = req.badv;
        trap.badv_we  = 1'b0;
        if (int_pending)
        begin
            trap.kind     = TRAP_ENTER;
            trap.ecode    = INT;
            trap.esubcode = '0;
        end
        else if (accept && req.op == OP_EXCP)
        begin
            trap.kind    = TRAP_ENTER;
            trap.badv_we = (req.ecode == ADE) || (req.ecode == ALE);
            if (req.ecode == ADE && req.esubcode == ESUB_ADEF)
                trap.badv = req.pc;   // fetch fault, badv is the pc
        end
        else if (accept && req.op == OP_ERTN)
            trap.kind = TRAP_RETURN;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            resp <= '0;
        else
        begin
            resp.flush <= 1'b0;
            if (trap.kind == TRAP_ENTER)
            begin
                resp.flush       <= 1'b1;
                resp.redirect_pc <= vec.eentry;
            end
            else if (trap.kind == TRAP_RETURN)
            begin
                resp.flush       <= 1'b1;
                resp.redirect_pc <= vec.era;
            end
            else if (csr_access)
            begin
                resp.rdata <= rd_data;   // value before the write
                if (csr_write)
                begin
                    resp.flush       <= 1'b1;
                    resp.redirect_pc <= req.pc + 32'd4;
                end
            end
        end
    end

endmodule

//--- csr/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_port_pkg::csr_wr_t wr,
    input  logic [13:0]           num,
    output logic                  ti,
    output logic [31:0]           rdata,
    output logic                  hit
);
    import csr_defs_pkg::*;

    logic [TIMER_W-1:0] tcfg;   // initval, periodic, en
    logic [TIMER_W-1:0] tval;
    logic               tcfg_we;
    logic               ticlr_we;
    logic               expire;

    assign tcfg_we  = wr.en && (wr.num == CSR_TCFG);
    assign ticlr_we = wr.en && (wr.num == CSR_TICLR) && wr.data[0];
    assign expire   = tcfg[0] && (tval == 1);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
            begin
                tcfg <= wr.data[TIMER_W-1:0];
                tval <= {wr.data[TIMER_W-1:2], 2'b00};   // one-shot start
            end
            else if (expire && tcfg[1])
                tval <= {tcfg[TIMER_W-1:2], 2'b00};
            else if (tcfg[0] && tval != 0)
                tval <= tval - TIMER_W'(1);

            if (ticlr_we)
                ti <= 1'b0;
            else if (expire)
                ti <= 1'b1;
        end
    end

    always_comb
    begin
        hit   = 1'b1;
        rdata = '0;
        case (num)
            CSR_TCFG:  rdata = {{(32-TIMER_W){1'b0}}, tcfg};
            CSR_TVAL:  rdata = {{(32-TIMER_W){1'b0}}, tval};
            CSR_TICLR: rdata = '0;   // write-only clear
            default:   hit = 1'b0;
        endcase
    end

endmodule

//--- csr/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_port_pkg::csr_wr_t wr,
    input  csr_port_pkg::csr_trap_t trap,
    input  logic [13:0]           num,
    input  logic [7:0]            hw_int,
    input  logic                  ti,
    output logic [31:0]           rdata,
    output logic                  hit,
    output csr_defs_pkg::crmd_t   crmd,
    output csr_defs_pkg::irq_ctl_t irq,
    output csr_defs_pkg::csr_vec_t vec
);
    import csr_defs_pkg::*;
    import csr_port_pkg::*;

    logic [1:0]       prmd_pplv;
    logic             prmd_pie;
    logic             euen_fpe;
    logic [IRQ_W-1:0] ecfg_lie;
    logic [1:0]       estat_is;
    logic [5:0]       estat_ecode;
    logic [8:0]       estat_esub;
    logic [31:0]      era;
    logic [31:0]      badv;
    logic [25:0]      eentry;   // bits 31:6
    logic [31:0]      save [4];
    logic [31:0]      tid;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= '{datm: 2'b00, datf: 2'b00, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'b00};
            prmd_pplv   <= '0;
            prmd_pie    <= 1'b0;
            euen_fpe    <= 1'b0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
            save        <= '{default: '0};
            tid         <= '0;
        end
        else if (trap.kind == TRAP_ENTER)
        begin
            prmd_pplv   <= crmd.plv;
            prmd_pie    <= crmd.ie;
            crmd.plv    <= 2'b00;
            crmd.ie     <= 1'b0;
            era         <= trap.era;
            estat_ecode <= trap.ecode;
            estat_esub  <= trap.esubcode;
            if (trap.badv_we)
                badv <= trap.badv;
        end
        else if (trap.kind == TRAP_RETURN)
        begin
            crmd.plv <= prmd_pplv;
            crmd.ie  <= prmd_pie;
        end
        else if (wr.en)
        begin
            case (wr.num)
                CSR_CRMD:
                begin
                    crmd.plv  <= wr.data[1:0];
                    crmd.ie   <= wr.data[2];
                    crmd.datf <= wr.data[6:5];
                    crmd.datm <= wr.data[8:7];
                    if (wr.data[4] ^ wr.data[3])   // da and pg never both set
                    begin
                        crmd.da <= wr.data[3];
                        crmd.pg <= wr.data[4];
                    end
                end
                CSR_PRMD:
                begin
                    prmd_pplv <= wr.data[1:0];
                    prmd_pie  <= wr.data[2];
                end
                CSR_EUEN:   euen_fpe <= wr.data[0];
                CSR_ECFG:   ecfg_lie <= wr.data[IRQ_W-1:0] & LIE_MASK;
                CSR_ESTAT:  estat_is <= wr.data[1:0];   // sw bits only
                CSR_ERA:    era <= wr.data;
                CSR_BADV:   badv <= wr.data;
                CSR_EENTRY: eentry <= wr.data[31:6];
                CSR_SAVE0:  save[0] <= wr.data;
                CSR_SAVE1:  save[1] <= wr.data;
                CSR_SAVE2:  save[2] <= wr.data;
                CSR_SAVE3:  save[3] <= wr.data;
                CSR_TID:    tid <= wr.data;
                default:    ;
            endcase
        end
    end

    always_comb
    begin
        hit   = 1'b1;
        rdata = '0;
        case (num)
            CSR_CRMD:   rdata = {23'b0, crmd};
            CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
            CSR_EUEN:   rdata = {31'b0, euen_fpe};
            CSR_ECFG:   rdata = {19'b0, ecfg_lie};
            // live interrupt lines, bit 12 (ipi) is gone
            CSR_ESTAT:  rdata = {1'b0, estat_esub, estat_ecode, 4'b0, ti, 1'b0, hw_int, estat_is};
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = {eentry, 6'b0};
            CSR_SAVE0:  rdata = save[0];
            CSR_SAVE1:  rdata = save[1];
            CSR_SAVE2:  rdata = save[2];
            CSR_SAVE3:  rdata = save[3];
            CSR_TID:    rdata = tid;
            default:    hit = 1'b0;
        endcase
    end

    assign irq = '{lie: ecfg_lie, sw_is: estat_is, ie: crmd.ie};
    assign vec = '{era: era, eentry: {eentry, 6'b0}};

endmodule

//--- common/csr_port_pkg.sv
package csr_port_pkg;

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5
    } csr_op_e;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        logic [13:0] num;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        flush;
        logic [31:0] redirect_pc;
    } csr_resp_t;

    // data is already merged under the xchg mask
    typedef struct packed {
        logic        en;
        logic [13:0] num;
        logic [31:0] data;
    } csr_wr_t;

    typedef enum logic [1:0] {
        TRAP_NONE   = 2'd0,
        TRAP_ENTER  = 2'd1,
        TRAP_RETURN = 2'd2
    } trap_kind_e;

    typedef struct packed {
        trap_kind_e  kind;
        logic [31:0] era;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        logic        badv_we;
    } csr_trap_t;

endpackage

//--- common/csr_defs_pkg.sv
package csr_defs_pkg;

    // architectural csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_EUEN   = 14'h002;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    localparam int TIMER_W = 20;

    // 11 timer, 10 reserved, 9:2 hw lines, 1:0 sw bits
    localparam int IRQ_W = 13;
    localparam logic [IRQ_W-1:0] LIE_MASK = 13'h1bff;

    typedef enum logic [5:0] {
        INT = 6'h00,
        ADE = 6'h08,
        ALE = 6'h09,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } ecode_e;

    localparam logic [8:0] ESUB_ADEF = 9'h000;

    // same bit order as the architectural CRMD
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic [31:0] era;
        logic [31:0] eentry;
    } csr_vec_t;

    typedef struct packed {
        logic [IRQ_W-1:0] lie;
        logic [1:0]       sw_is;
        logic             ie;
    } irq_ctl_t;

endpackage
